/* src.f */
hdl/pcie_tlp_pkg.sv
hdl/dma_regs_pkg.sv
hdl/dma_ifs.sv
hdl/rx_reg_decoder.sv
hdl/notify_channel.sv
hdl/tx_arbiter.sv
hdl/pcie_notify_endpoint.sv
test/tb_pcie_notify_endpoint.sv

/* run.sh */
#!/bin/sh
# Build and run the notification endpoint testbench with Verilator

cd "$(dirname "$0")" || exit 1
rm -f build.log sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_pcie_notify_endpoint \
    -f src.f -o tb_sim > build.log 2>&1 \
    && ./obj_dir/tb_sim > sim.log 2>&1 \
    || { cat build.log sim.log 2>/dev/null; echo "Build or simulation error"; exit 1; }

cat sim.log
grep -q "Result: FAILED" sim.log && exit 1 || exit 0

/* test/notify_cases.txt */
# W chan reg data bar_hit fmt len : one register write TLP, fields in hex
# D chan data count : count doorbells to chan, data word counting up by one
W 0 0 10001007 1 40 1
W 0 1 00000001 1 40 1
D 0 a0000000 3
W 1 0 20002000 1 40 1
W 1 1 00000002 1 40 1
D 1 b0000000 1
W 1 0 dead0000 0 40 1
W 1 1 beef0000 1 00 1
W 1 0 cafe0000 1 40 2
W 5 2 11111111 1 40 1
W 7 2 33333333 1 40 1
W 1 3 22222222 1 40 1
D 1 b0000100 2
W 2 0 30003ff8 1 40 1
W 3 1 0000abcd 1 40 1
D 0 a0000100 1
D 1 b0000200 1
D 2 c0000000 1
D 3 d0000000 1
D 2 c0001000 513
W 2 1 00000003 1 40 1
D 2 c0002000 1

/* test/tb_pcie_notify_endpoint.sv */
// Notification endpoint testbench
module tb_pcie_notify_endpoint
    import pcie_tlp_pkg::*, dma_regs_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    logic       trn_clk;
    logic       reset;
    qword_t     trn_rd;
    logic       trn_rsof_n;
    logic       trn_reof_n;
    logic       trn_rsrc_rdy_n;
    logic [6:0] trn_rbar_hit_n;
    logic       trn_rdst_rdy_n;
    qword_t     trn_td;
    logic [7:0] trn_trem_n;
    logic       trn_tsof_n;
    logic       trn_teof_n;
    logic       trn_tsrc_rdy_n;
    logic       trn_tdst_rdy_n;
    logic [7:0] cfg_bus_number;
    logic [4:0] cfg_device_number;
    logic [2:0] cfg_function_number;

    typedef struct packed {
        chan_idx_t   chan;
        logic [1:0]  sel;
        dword_t      data;
        logic        bar_hit;
        logic [7:0]  fmt;      // Header byte 0
        tlp_len_t    len;
        logic [15:0] count;    // Doorbell repeats
    } case_t;

    case_t         cases [$];
    int            num_ops;    // Writes plus doorbells
    bit            loaded;
    int            errors;
    int            checks;
    int            tlp_count;

    // ----------------------------------------
    // Reference model of the channels
    // ----------------------------------------
    pcie_addr_t    m_base [NUM_CHANNELS];
    ring_off_t     m_off [NUM_CHANNELS];
    seq_t          m_seq [NUM_CHANNELS];
    pcie_addr_t    exp_addr [NUM_CHANNELS][$];  // Expected slot address
    qword_t        exp_pay [NUM_CHANNELS][$];   // Expected {seq, doorbell word}
    requester_id_t exp_rid;

    bit            in_tlp;     // Between sof and eof
    int            beat_idx;
    int            cur_tag;
    bit            cur_ok;     // Tag matched a pending doorbell

    assign exp_rid = {cfg_bus_number, cfg_device_number, cfg_function_number};

    pcie_notify_endpoint u_pcie_notify_endpoint (
        .trn_clk             (trn_clk),
        .reset               (reset),
        .trn_rd              (trn_rd),
        .trn_rsof_n          (trn_rsof_n),
        .trn_reof_n          (trn_reof_n),
        .trn_rsrc_rdy_n      (trn_rsrc_rdy_n),
        .trn_rbar_hit_n      (trn_rbar_hit_n),
        .trn_rdst_rdy_n      (trn_rdst_rdy_n),
        .trn_td              (trn_td),
        .trn_trem_n          (trn_trem_n),
        .trn_tsof_n          (trn_tsof_n),
        .trn_teof_n          (trn_teof_n),
        .trn_tsrc_rdy_n      (trn_tsrc_rdy_n),
        .trn_tdst_rdy_n      (trn_tdst_rdy_n),
        .cfg_bus_number      (cfg_bus_number),
        .cfg_device_number   (cfg_device_number),
        .cfg_function_number (cfg_function_number)
    );

    initial begin
        trn_clk = 1'b0;
        forever #5 trn_clk = ~trn_clk;  // 100 MHz
    end

    // ----------------------------------------
    // Compare tasks
    // ----------------------------------------
    task automatic check_qword(input string name, input qword_t exp, input qword_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("Fail %s: expected %h actual %h", name, exp, act);
        end
    endtask

    task automatic check_addr(input string name, input pcie_addr_t exp, input pcie_addr_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("Fail %s: expected %h actual %h", name, exp, act);
        end
    endtask

    task automatic check_header(input string name, input tlp_fmt_type_e exp_fmt,
                                input requester_id_t exp_id, input qword_t act);
        tlp_fmt_type_e act_fmt;
        requester_id_t act_id;
        act_fmt = tlp_fmt_type_e'(act[63:56]);
        act_id  = act[31:16];
        checks++;
        if (act_fmt !== exp_fmt || act_id !== exp_id) begin
            errors++;
            $display("Fail %s: expected fmt %h rid %h actual fmt %h rid %h",
                     name, exp_fmt, exp_id, act_fmt, act_id);
        end
    endtask

    // Register effect of one accepted write
    task automatic model_write(input int c, input reg_sel_e sel, input dword_t data);
        case (sel)
            REG_ADDR_LO: begin
                m_base[c][31:0] = {data[31:3], 3'b000};  // Qword aligned
                m_off[c]        = '0;
            end
            REG_ADDR_HI: begin
                m_base[c][63:32] = data;
                m_off[c]         = '0;
            end
            REG_DOORBELL: begin
                exp_addr[c].push_back(m_base[c] + pcie_addr_t'(m_off[c]));
                exp_pay[c].push_back({m_seq[c], data});
                m_seq[c] = m_seq[c] + 1;
                m_off[c] = ring_off_t'((int'(m_off[c]) + 8) % RING_BYTES);  // Ring wrap
            end
            default: ;  // Unmapped
        endcase
    endtask

    // Never ring a channel with a TLP still out
    task automatic wait_channel_idle(input int c);
        if (exp_addr[c].size() != 0) begin
            while (exp_addr[c].size() != 0) @(negedge trn_clk);
            repeat (2) @(negedge trn_clk);  // ack drop and return to IDLE
        end
    endtask

    // Two-beat MWr32 on the receive link
    task automatic send_write(input case_t tc, input dword_t data);
        qword_t beat0;
        qword_t beat1;
        dword_t addr;
        bit     accept;
        addr   = {25'd0, tc.chan, tc.sel, 2'b00};
        beat0  = {tc.fmt, 14'd0, tc.len, 16'h0100, 8'h00, 4'h0, 4'hF};
        beat1  = {addr, data};
        accept = tc.bar_hit && tc.fmt == 8'h40 && tc.len == 10'd1 &&
                 int'(tc.chan) < NUM_CHANNELS;
        if (int'(tc.chan) < NUM_CHANNELS) wait_channel_idle(int'(tc.chan));
        @(negedge trn_clk);
        trn_rd         = beat0;
        trn_rsof_n     = 1'b0;
        trn_reof_n     = 1'b1;
        trn_rsrc_rdy_n = 1'b0;
        trn_rbar_hit_n = tc.bar_hit ? 7'h7e : 7'h7d;  // BAR0 or BAR1
        @(negedge trn_clk);
        trn_rd         = beat1;
        trn_rsof_n     = 1'b1;
        trn_reof_n     = 1'b0;
        checks++;
        if (trn_rdst_rdy_n !== 1'b0) begin
            errors++;
            $display("Receive destination ready is not asserted during a write");
        end
        if (accept) model_write(int'(tc.chan), reg_sel_e'(tc.sel), data);
        @(negedge trn_clk);
        trn_rsrc_rdy_n = 1'b1;  // Link idle
        trn_reof_n     = 1'b1;
        trn_rbar_hit_n = 7'h7f;
    endtask

    task automatic run_case(input case_t tc);
        for (int i = 0; i < int'(tc.count); i++) begin
            send_write(tc, tc.data + dword_t'(i));
        end
    endtask

    task automatic load_cases();
        int          fd;
        int          n;
        string       tok;
        string       rest;
        case_t       tc;
        logic [31:0] f_chan;
        logic [31:0] f_sel;
        logic [31:0] f_data;
        logic [31:0] f_bar;
        logic [31:0] f_fmt;
        logic [31:0] f_len;
        logic [31:0] f_cnt;
        fd = $fopen("test/notify_cases.txt", "r");
        if (fd == 0) begin
            errors++;
            $display("Cannot open the case file test/notify_cases.txt");
        end else begin
            while ($fscanf(fd, "%s", tok) == 1) begin
                tc = '0;
                if (tok == "W") begin
                    n = $fscanf(fd, "%h %h %h %h %h %h",
                                f_chan, f_sel, f_data, f_bar, f_fmt, f_len);
                    f_cnt = 1;
                end else if (tok == "D") begin
                    n = $fscanf(fd, "%h %h %d", f_chan, f_data, f_cnt);
                    f_sel = 32'(REG_DOORBELL);  // Always a good doorbell
                    f_bar = 1;
                    f_fmt = 32'h40;
                    f_len = 1;
                    n = n + 3;
                end else begin
                    void'($fgets(rest, fd));  // Comment line
                    n = -1;
                end
                if (n == 6) begin
                    tc.chan    = f_chan[2:0];
                    tc.sel     = f_sel[1:0];
                    tc.data    = f_data;
                    tc.bar_hit = f_bar[0];
                    tc.fmt     = f_fmt[7:0];
                    tc.len     = f_len[9:0];
                    tc.count   = f_cnt[15:0];
                    cases.push_back(tc);
                    num_ops += int'(tc.count);
                end else if (n >= 0) begin
                    errors++;
                    $display("Malformed line in the case file after case %0d", cases.size());
                end
            end
            $fclose(fd);
        end
        loaded = 1'b1;
    endtask

    function automatic int pending_count();
        int total;
        total = 0;
        for (int c = 0; c < NUM_CHANNELS; c++) total += exp_addr[c].size();
        return total;
    endfunction

    // ----------------------------------------
    // Stimulus and end of run
    // ----------------------------------------
    initial begin
        reset               = 1'b1;
        trn_rd              = '0;
        trn_rsof_n          = 1'b1;
        trn_reof_n          = 1'b1;
        trn_rsrc_rdy_n      = 1'b1;
        trn_rbar_hit_n      = 7'h7f;
        trn_tdst_rdy_n      = 1'b0;
        cfg_bus_number      = 8'h3a;
        cfg_device_number   = 5'h11;
        cfg_function_number = 3'h5;
        errors              = 0;
        checks              = 0;
        tlp_count           = 0;
        num_ops             = 0;
        for (int c = 0; c < NUM_CHANNELS; c++) begin
            m_base[c] = '0;
            m_off[c]  = '0;
            m_seq[c]  = '0;
        end
        load_cases();
        repeat (3) @(posedge trn_clk);
        @(negedge trn_clk);
        reset = 1'b0;
        checks++;
        if (trn_tsrc_rdy_n !== 1'b1) begin
            errors++;
            $display("Transmit source ready is active right after reset");
        end
        foreach (cases[i]) run_case(cases[i]);
        while (pending_count() != 0) @(negedge trn_clk);
        repeat (20) @(negedge trn_clk);  // Catch any extra TLP
        $display("Checks %0d, TLPs %0d, errors %0d", checks, tlp_count, errors);
        if (errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

    // Random back-pressure on the transmit port
    initial begin
        void'($urandom(32'hf960));
        forever begin
            @(negedge trn_clk);
            if (reset) trn_tdst_rdy_n <= 1'b0;
            else       trn_tdst_rdy_n <= ($urandom % 4) == 0;  // Stall about one beat in four
        end
    end

    // ----------------------------------------
    // Transmit monitor and scoreboard
    // ----------------------------------------
    always @(posedge trn_clk) begin
        if (reset) begin
            in_tlp   = 1'b0;
            beat_idx = 0;
            cur_ok   = 1'b0;
        end else if (!trn_tsrc_rdy_n && !trn_tdst_rdy_n) begin
            if (!trn_tsof_n) begin
                if (in_tlp) begin
                    errors++;
                    $display("Start of TLP arrived inside another TLP");
                end
                in_tlp   = 1'b1;
                beat_idx = 0;
            end else if (!in_tlp) begin
                errors++;
                $display("Transmit beat outside any TLP");
            end
            if (trn_trem_n !== 8'h00) begin
                errors++;
                $display("trn_trem_n is not zero on a transmit beat");
            end
            case (beat_idx)
                0: begin
                    cur_tag = int'(trn_td[15:8]);  // Tag names the channel
                    cur_ok  = 1'b0;
                    if (cur_tag < NUM_CHANNELS) cur_ok = exp_addr[cur_tag].size() != 0;
                    if (cur_ok) begin
                        check_header($sformatf("tlp %0d ch%0d header", tlp_count, cur_tag),
                                     MWR64_4DW_DATA, exp_rid, trn_td);
                        check_qword($sformatf("tlp %0d ch%0d beat0", tlp_count, cur_tag),
                                    {8'h60, 14'd0, 10'd2, exp_rid, 8'(cur_tag), 4'hF, 4'hF},
                                    trn_td);
                    end else begin
                        errors++;
                        $display("TLP with tag %0d that no doorbell asked for", cur_tag);
                    end
                end
                1: if (cur_ok) check_addr($sformatf("tlp %0d ch%0d address", tlp_count, cur_tag),
                                          exp_addr[cur_tag][0], trn_td);
                2: begin
                    if (cur_ok) begin
                        check_qword($sformatf("tlp %0d ch%0d payload", tlp_count, cur_tag),
                                    exp_pay[cur_tag][0], trn_td);
                        void'(exp_addr[cur_tag].pop_front());
                        void'(exp_pay[cur_tag].pop_front());
                        cur_ok = 1'b0;
                    end
                end
                default: begin
                    errors++;
                    $display("TLP longer than three beats");
                end
            endcase
            if (!trn_teof_n) begin
                if (beat_idx != 2) begin
                    errors++;
                    $display("TLP ended after %0d beats", beat_idx + 1);
                    if (cur_ok) begin
                        void'(exp_addr[cur_tag].pop_front());  // Keep the run going
                        void'(exp_pay[cur_tag].pop_front());
                    end
                end
                in_tlp = 1'b0;
                tlp_count++;
            end
            beat_idx++;
        end
    end

    // Watchdog sized from the case count
    initial begin
        wait (loaded);
        repeat ((num_ops + 1) * 200) @(posedge trn_clk);
        $display("Timeout: the run did not finish within %0d cycles", (num_ops + 1) * 200);
        $display("Result: FAILED");
        $finish;
    end

endmodule

/* hdl/pcie_notify_endpoint.sv */
// PCIe notification endpoint top
module pcie_notify_endpoint
    import pcie_tlp_pkg::*, dma_regs_pkg::*;
(
    input  logic       trn_clk,
    input  logic       reset,

    // Rx local-link
    input  qword_t     trn_rd,
    input  logic       trn_rsof_n,
    input  logic       trn_reof_n,
    input  logic       trn_rsrc_rdy_n,
    input  logic [6:0] trn_rbar_hit_n,
    output logic       trn_rdst_rdy_n,

    // Tx local-link
    output qword_t     trn_td,
    output logic [7:0] trn_trem_n,
    output logic       trn_tsof_n,
    output logic       trn_teof_n,
    output logic       trn_tsrc_rdy_n,
    input  logic       trn_tdst_rdy_n,

    // Configuration
    input  logic [7:0] cfg_bus_number,
    input  logic [4:0] cfg_device_number,
    input  logic [2:0] cfg_function_number
);

    requester_id_t requester_id;
    logic          tsof;
    logic          teof;
    logic          tsrc_rdy;

    reg_write_if  regs_bus ();               // Decoder to all channels
    tlp_stream_if chan_tx [NUM_CHANNELS] ();  // One stream per channel

    assign requester_id   = {cfg_bus_number, cfg_device_number, cfg_function_number};
    assign trn_rdst_rdy_n = 1'b0;    // Always listen
    assign trn_trem_n     = 8'h00;   // Full qword on every beat

    // ----------------------------------------
    // Receive side
    // ----------------------------------------
    rx_reg_decoder u_rx_reg_decoder (
        .trn_clk  (trn_clk),
        .reset    (reset),
        .rd       (trn_rd),
        .rsof     (!trn_rsof_n),
        .reof     (!trn_reof_n),
        .rsrc_rdy (!trn_rsrc_rdy_n),
        .bar0_hit (!trn_rbar_hit_n[0]),
        .regs     (regs_bus.src)
    );

    for (genvar g = 0; g < NUM_CHANNELS; g++) begin : g_chan
        notify_channel #(.CHANNEL_ID(g)) u_notify_channel (
            .trn_clk      (trn_clk),
            .reset        (reset),
            .requester_id (requester_id),
            .regs         (regs_bus.dst),
            .tx           (chan_tx[g].chan)
        );
    end

    // ----------------------------------------
    // Transmit side
    // ----------------------------------------
    tx_arbiter u_tx_arbiter (
        .trn_clk  (trn_clk),
        .reset    (reset),
        .chans    (chan_tx),
        .td       (trn_td),
        .tsof     (tsof),
        .teof     (teof),
        .tsrc_rdy (tsrc_rdy),
        .tdst_rdy (!trn_tdst_rdy_n)
    );

    assign trn_tsof_n     = !tsof;      // Active low at the core
    assign trn_teof_n     = !teof;
    assign trn_tsrc_rdy_n = !tsrc_rdy;

endmodule

/* hdl/tx_arbiter.sv */
// Round-robin transmit arbiter
module tx_arbiter
    import pcie_tlp_pkg::*, dma_regs_pkg::*;
(
    input  logic      trn_clk,
    input  logic      reset,
    tlp_stream_if.arb chans [NUM_CHANNELS],
    output qword_t    td,        // Granted beat
    output logic      tsof,
    output logic      teof,
    output logic      tsrc_rdy,
    input  logic      tdst_rdy   // Core can take a beat
);

    typedef enum logic [1:0] {
        SCAN,      // Looking for a requester
        GRANT,     // ack high, TLP in flight
        WAIT_DROP  // eof sent, waiting for req low
    } arb_state_e;

    arb_state_e state;
    chan_sel_t  grant;  // Channel owning the port
    chan_sel_t  last;   // Last granted, round-robin base
    chan_sel_t  pick;   // Next requester after last
    logic       found;
    logic       ack_on;
    logic       eof_done;
    logic [$clog2(NOTIFY_BEATS)-1:0] beat_cnt;  // Beats of the current TLP

    logic [NUM_CHANNELS-1:0] req_vec;
    logic [NUM_CHANNELS-1:0] valid_vec;
    logic [NUM_CHANNELS-1:0] sof_vec;
    logic [NUM_CHANNELS-1:0] eof_vec;
    logic [NUM_CHANNELS-1:0] ack_vec;
    qword_t                  data_vec [NUM_CHANNELS];

    // ----------------------------------------
    // Flatten the channel ports
    // ----------------------------------------
    for (genvar i = 0; i < NUM_CHANNELS; i++) begin : g_chan
        assign req_vec[i]     = chans[i].req;
        assign valid_vec[i]   = chans[i].valid;
        assign sof_vec[i]     = chans[i].sof;
        assign eof_vec[i]     = chans[i].eof;
        assign data_vec[i]    = chans[i].data;
        assign ack_vec[i]     = ack_on && (grant == chan_sel_t'(i));
        assign chans[i].ack   = ack_vec[i];
        assign chans[i].ready = ack_vec[i] && tdst_rdy;  // Only the owner sees ready
    end

    // First requester after the last grant
    always_comb begin
        pick  = last;
        found = 1'b0;
        for (int k = 1; k <= NUM_CHANNELS; k++) begin
            if (!found && req_vec[(int'(last) + k) % NUM_CHANNELS]) begin
                pick  = chan_sel_t'((int'(last) + k) % NUM_CHANNELS);
                found = 1'b1;
            end
        end
    end

    // ----------------------------------------
    // Grant FSM
    // ----------------------------------------
    always_ff @(posedge trn_clk) begin
        if (reset) begin
            state    <= SCAN;
            grant    <= '0;
            last     <= chan_sel_t'(NUM_CHANNELS - 1);  // First pick is channel 0
            beat_cnt <= '0;
        end else begin
            case (state)
                SCAN: begin
                    if (found) begin
                        grant    <= pick;
                        last     <= pick;
                        beat_cnt <= '0;
                        state    <= GRANT;   // ack next cycle
                    end
                end
                GRANT: begin
                    if (tsrc_rdy && tdst_rdy) beat_cnt <= beat_cnt + 1'b1;
                    if (eof_done) state <= WAIT_DROP;
                end
                WAIT_DROP: if (!req_vec[grant]) state <= SCAN;  // Drops ack
                default: state <= SCAN;
            endcase
        end
    end

    assign ack_on = (state != SCAN);

    // Combinational mux of the owner
    assign td       = data_vec[grant];
    assign tsrc_rdy = ack_on && valid_vec[grant];
    assign tsof     = tsrc_rdy && sof_vec[grant];
    assign teof     = tsrc_rdy && eof_vec[grant];
    assign eof_done = teof && tdst_rdy;

    assert property (@(posedge trn_clk) disable iff (reset)
        $onehot0(ack_vec));

    // A granted channel sends a whole TLP before eof
    assert property (@(posedge trn_clk) disable iff (reset)
        eof_done |-> (beat_cnt == NOTIFY_BEATS - 1));

endmodule

/* hdl/notify_channel.sv */
// Notification channel with TLP builder
module notify_channel
    import pcie_tlp_pkg::*, dma_regs_pkg::*;
#(
    parameter int CHANNEL_ID = 0
)
(
    input  logic          trn_clk,
    input  logic          reset,
    input  requester_id_t requester_id,  // From cfg bus/dev/fn
    reg_write_if.dst      regs,
    tlp_stream_if.chan    tx
);

    typedef enum logic [2:0] {
        IDLE,     // No doorbell pending
        REQ,      // Waiting for ack
        BEAT0,    // dw0, dw1
        BEAT1,    // 64-bit address
        BEAT2,    // Sequence and doorbell word
        RELEASE   // req low, waiting for ack low
    } chan_state_e;

    chan_state_e state;
    pcie_addr_t  base_addr;  // Ring base, qword aligned
    ring_off_t   ring_off;   // Next slot in the ring
    seq_t        seq;        // Notifications sent
    dword_t      db_word;    // Latched doorbell data
    logic        hit;        // Write addressed to this channel
    logic        beat_done;  // Beat accepted
    dword_t      hdr_dw0;
    dword_t      hdr_dw1;

    assign hit       = regs.wr_valid && (regs.chan == chan_idx_t'(CHANNEL_ID));
    assign beat_done = tx.valid && tx.ready;

    // MWr64 header, tag is the channel index
    assign hdr_dw0 = {8'(MWR64_4DW_DATA), 14'd0, MWR_LENGTH_DW};
    assign hdr_dw1 = {requester_id, TLP_TAG_W'(CHANNEL_ID), FULL_BE, FULL_BE};

    // ----------------------------------------
    // Handshake and beat sequencing
    // ----------------------------------------
    always_ff @(posedge trn_clk) begin
        if (reset) begin
            state     <= IDLE;
            base_addr <= '0;
            ring_off  <= '0;
            seq       <= '0;
        end else begin
            case (state)
                IDLE:    if (hit && regs.sel == REG_DOORBELL) state <= REQ;
                REQ:     if (tx.ack) state <= BEAT0;
                BEAT0:   if (beat_done) state <= BEAT1;
                BEAT1:   if (beat_done) state <= BEAT2;
                BEAT2: begin
                    if (beat_done) begin
                        state    <= RELEASE;
                        seq      <= seq + seq_t'(1);
                        ring_off <= ring_off + ring_off_t'(NOTIFY_STRIDE);  // Wraps at ring end
                    end
                end
                RELEASE: if (!tx.ack) state <= IDLE;   // Four-phase close
                default: state <= IDLE;
            endcase
            // Base writes restart the ring
            if (hit && regs.sel == REG_ADDR_LO) begin
                base_addr[31:0] <= {regs.data[31:3], 3'b000};
                ring_off        <= '0;
            end
            if (hit && regs.sel == REG_ADDR_HI) begin
                base_addr[63:32] <= regs.data;
                ring_off         <= '0;
            end
        end
    end

    // Doorbell word, only taken when idle
    always_ff @(posedge trn_clk) begin
        if (state == IDLE && hit && regs.sel == REG_DOORBELL) begin
            db_word <= regs.data;
        end
    end

    // ----------------------------------------
    // Stream outputs
    // ----------------------------------------
    assign tx.req   = state inside {REQ, BEAT0, BEAT1, BEAT2};
    assign tx.valid = state inside {BEAT0, BEAT1, BEAT2};
    assign tx.sof   = (state == BEAT0);
    assign tx.eof   = (state == BEAT2);

    always_comb begin
        case (state)
            BEAT0:   tx.data = {hdr_dw0, hdr_dw1};
            BEAT1:   tx.data = base_addr + pcie_addr_t'(ring_off);
            default: tx.data = {seq, db_word};
        endcase
    end

    // req only drops right after the eof beat went out
    assert property (@(posedge trn_clk) disable iff (reset)
        $fell(tx.req) |-> $past(tx.valid && tx.ready && tx.eof));

    // No beat without a grant from the arbiter
    assert property (@(posedge trn_clk) disable iff (reset)
        tx.valid |-> tx.ack);

endmodule

/* hdl/rx_reg_decoder.sv */
// Receive TLP register decoder
module rx_reg_decoder
    import pcie_tlp_pkg::*, dma_regs_pkg::*;
(
    input  logic     trn_clk,
    input  logic     reset,
    input  qword_t   rd,        // Receive beat
    input  logic     rsof,      // Start of TLP
    input  logic     reof,      // End of TLP
    input  logic     rsrc_rdy,  // Beat valid
    input  logic     bar0_hit,  // TLP targets BAR0
    reg_write_if.src regs
);

    typedef enum logic [1:0] {
        IDLE,  // Waiting for sof
        HDR,   // Good header seen, expecting data beat
        DATA,  // Write pulse cycle
        DROP   // Skipping to eof
    } rx_state_e;

    rx_state_e state;
    logic      beat;      // Beat on the bus
    logic      hdr_ok;    // Header passes all checks
    dword_t    addr_dw;   // dw2 of the second beat
    chan_idx_t chan_q;
    reg_sel_e  sel_q;
    dword_t    data_q;

    assign beat    = rsrc_rdy;
    assign addr_dw = rd[63:32];

    // BAR0, 1DW MWr32, and must not end on the header beat
    assign hdr_ok = bar0_hit && (rd[63:56] == MWR32_3DW) &&
                    (rd[41:32] == RX_LENGTH_DW) && !reof;

    // ----------------------------------------
    // Header and length tracking
    // ----------------------------------------
    always_ff @(posedge trn_clk) begin
        if (reset) begin
            state <= IDLE;
        end else begin
            case (state)
                IDLE, DATA: begin
                    state <= IDLE;                 // DATA lasts one cycle
                    if (beat && rsof) begin
                        if (hdr_ok) begin
                            state <= HDR;
                        end else if (!reof) begin
                            state <= DROP;         // Wrong TLP, skip body
                        end
                    end
                end
                HDR: begin
                    if (beat) begin
                        if (reof && !rsof) begin
                            state <= DATA;         // Exactly two beats
                        end else if (reof) begin
                            state <= IDLE;
                        end else begin
                            state <= DROP;         // Too long
                        end
                    end
                end
                DROP: if (beat && reof) state <= IDLE;
                default: state <= IDLE;
            endcase
        end
    end

    // Address and data from the eof beat
    always_ff @(posedge trn_clk) begin
        if (state == HDR && beat && reof) begin
            chan_q <= addr_dw[BAR_CHAN_MSB:BAR_CHAN_LSB];
            sel_q  <= reg_sel_e'(addr_dw[BAR_SEL_MSB:BAR_SEL_LSB]);
            data_q <= rd[31:0];
        end
    end

    assign regs.wr_valid = (state == DATA);  // One cycle after eof
    assign regs.chan     = chan_q;
    assign regs.sel      = sel_q;
    assign regs.data     = data_q;

    // Back-to-back writes still leave a gap of at least one cycle
    assert property (@(posedge trn_clk) disable iff (reset)
        regs.wr_valid |=> !regs.wr_valid);

endmodule

/* hdl/dma_ifs.sv */
// Internal register and stream interfaces

// Register write broadcast, decoder to channels
interface reg_write_if
    import pcie_tlp_pkg::*, dma_regs_pkg::*;
();
    logic      wr_valid;  // Single-cycle pulse
    chan_idx_t chan;      // Target channel
    reg_sel_e  sel;       // Target register
    dword_t    data;      // Write data

    modport src (
        output wr_valid,
        output chan,
        output sel,
        output data
    );

    modport dst (
        input  wr_valid,
        input  chan,
        input  sel,
        input  data
    );
endinterface

// TLP stream with four-phase req/ack, channel to arbiter
interface tlp_stream_if
    import pcie_tlp_pkg::*;
();
    logic   req;    // Channel wants the tx port
    logic   ack;    // Arbiter grants the port
    qword_t data;   // Beat data
    logic   sof;    // First beat
    logic   eof;    // Last beat
    logic   valid;  // Beat present
    logic   ready;  // Beat taken this cycle

    modport chan (
        output req, data, sof, eof, valid,
        input  ack, ready
    );

    modport arb (
        input  req, data, sof, eof, valid,
        output ack, ready
    );
endinterface

/* hdl/dma_regs_pkg.sv */
// Notification register map
package dma_regs_pkg;

    // ----------------------------------------
    // Channels
    // ----------------------------------------
    localparam int NUM_CHANNELS = 4;
    localparam int CHAN_SEL_W   = $clog2(NUM_CHANNELS);

    typedef logic [2:0] chan_idx_t;             // Room for indexes past the last one
    typedef logic [CHAN_SEL_W-1:0] chan_sel_t;  // Arbiter grant index

    // Register select, address bits 3:2
    typedef enum logic [1:0] {
        REG_ADDR_LO  = 2'd0,  // Ring base, low half
        REG_ADDR_HI  = 2'd1,  // Ring base, high half
        REG_DOORBELL = 2'd2,  // Send one notification
        REG_NONE     = 2'd3   // Unmapped
    } reg_sel_e;

    // BAR0 byte address fields
    localparam int BAR_CHAN_MSB = 6;
    localparam int BAR_CHAN_LSB = 4;
    localparam int BAR_SEL_MSB  = 3;
    localparam int BAR_SEL_LSB  = 2;

    // ----------------------------------------
    // Ring geometry
    // ----------------------------------------
    localparam int RING_BYTES    = 4096;
    localparam int NOTIFY_STRIDE = 8;           // One qword slot per notification
    typedef logic [$clog2(RING_BYTES)-1:0] ring_off_t;
    typedef logic [31:0] seq_t;

endpackage

/* hdl/pcie_tlp_pkg.sv */
// PCIe local-link TLP definitions
package pcie_tlp_pkg;

    // ----------------------------------------
    // Local-link data types
    // ----------------------------------------
    typedef logic [63:0] qword_t;         // One 64-bit trn beat
    typedef logic [31:0] dword_t;         // One TLP DWORD
    typedef logic [63:0] pcie_addr_t;     // Host byte address
    typedef logic [15:0] requester_id_t;  // Bus, device, function

    localparam int TLP_LEN_W = 10;        // Length field in dw0
    typedef logic [TLP_LEN_W-1:0] tlp_len_t;

    // ----------------------------------------
    // Header byte 0, fmt and type together
    // ----------------------------------------
    typedef enum logic [7:0] {
        MRD32          = 8'h00,  // Memory read, 3DW header
        MWR32_3DW      = 8'h40,  // Memory write, 3DW header with data
        MWR64_4DW_DATA = 8'h60   // Memory write, 4DW header with data
    } tlp_fmt_type_e;

    // Outgoing notification TLP
    localparam int       TLP_TAG_W     = 8;         // Tag field in dw1
    localparam tlp_len_t MWR_LENGTH_DW = 10'd2;     // Two DWORDs of payload
    localparam logic [3:0] FULL_BE     = 4'hF;      // All bytes enabled
    localparam int       NOTIFY_BEATS  = 3;         // Header, address, payload

    // Receive length accepted by the decoder
    localparam tlp_len_t RX_LENGTH_DW  = 10'd1;

endpackage
